// File: hw/core_pkg.sv
`default_nettype none

// types shared by the core side of the fetch subsystem
package core_pkg;

    // architectural widths
    localparam int XLEN = 64;
    localparam int ILEN = 32;

    // address or data word of the core
    typedef logic [XLEN-1:0] xlen_t;

    // one uncompressed instruction
    typedef logic [ILEN-1:0] inst_t;

    // source chosen for the next pc
    //   seq  : pc + 4 after a delivery
    //   jump : jal or taken branch, ex_pc + imm
    //   jalr : rs1 + imm, bit 0 cleared
    //   trap : mtvec
    //   hold : pc unchanged
    typedef enum logic [2:0] {
        REDIR_SEQ,
        REDIR_JUMP,
        REDIR_JALR,
        REDIR_TRAP,
        REDIR_HOLD
    } redirect_e;

    // byte step between sequential instructions
    localparam xlen_t INST_STEP = xlen_t'(ILEN / 8);

endpackage

`default_nettype wire

// File: hw/rbus_pkg.sv
`default_nettype none

// types of the instruction read channel
package rbus_pkg;

    // bus address and read data
    typedef logic [63:0] raddr_t;
    typedef logic [63:0] rdata_t;

    // transfer size, a byte lane mask
    typedef logic [7:0] rsize_t;

    // four bytes, one instruction word
    localparam rsize_t RSIZE_WORD = 8'b0000_1111;

    // fetch control states
    //   idle : waiting to issue
    //   addr : address phase, ar_valid high
    //   data : data phase, r_ready high
    typedef enum logic [1:0] {
        ST_IDLE,
        ST_ADDR,
        ST_DATA
    } fetch_state_e;

endpackage

`default_nettype wire

// File: hw/rbus_if.sv
`timescale 1ns/1ps
`default_nettype none

// read channel with split address and data phases
interface rbus_if import rbus_pkg::*; ();

    // address phase
    logic   ar_valid;
    logic   ar_ready;
    raddr_t ar_addr;
    rsize_t ar_size;

    // data phase
    logic   r_valid;
    logic   r_ready;
    rdata_t r_data;

    // fetch side
    modport master (
        output ar_valid, ar_addr, ar_size, r_ready,
        input  ar_ready, r_valid, r_data
    );

    // memory side
    modport slave (
        input  ar_valid, ar_addr, ar_size, r_ready,
        output ar_ready, r_valid, r_data
    );

endinterface

`default_nettype wire

// File: hw/pc_gen.sv
`timescale 1ns/1ps
`default_nettype none

module pc_gen import core_pkg::*; #(
    parameter xlen_t RESET_PC = 64'h0000_0000_8000_0000
) (
    input  wire logic  clk,
    input  wire logic  rst_n_i,
    input  wire logic  jal_i,
    input  wire logic  branch_i,
    input  wire logic  jalr_i,
    input  wire logic  trap_i,
    input  wire xlen_t alu_res_i,
    input  wire xlen_t ex_pc_i,
    input  wire xlen_t imm_i,
    input  wire xlen_t rs1_data_i,
    input  wire xlen_t mtvec_i,
    input  wire logic  advance_i,
    output xlen_t      pc_o,
    output logic       redirect_o
);

    xlen_t     pc_q;
    xlen_t     pc_d;
    xlen_t     jalr_sum;
    redirect_e sel;

    assign jalr_sum = rs1_data_i + imm_i;

    // priority: jump, jalr, trap, then sequential
    // branch is taken when the alu result is zero
    always_comb begin
        if (jal_i || (branch_i && (alu_res_i == '0))) begin
            sel = REDIR_JUMP;
        end else if (jalr_i) begin
            sel = REDIR_JALR;
        end else if (trap_i) begin
            sel = REDIR_TRAP;
        end else if (advance_i) begin
            sel = REDIR_SEQ;
        end else begin
            sel = REDIR_HOLD;
        end
    end

    always_comb begin
        case (sel)
            REDIR_JUMP: pc_d = ex_pc_i + imm_i;
            // jalr target has bit 0 forced low
            REDIR_JALR: pc_d = {jalr_sum[63:1], 1'b0};
            REDIR_TRAP: pc_d = mtvec_i;
            REDIR_SEQ:  pc_d = pc_q + INST_STEP;
            default:    pc_d = pc_q;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            pc_q <= RESET_PC;
        end else begin
            pc_q <= pc_d;
        end
    end

    assign pc_o = pc_q;

    // any non-sequential source counts as a redirect
    assign redirect_o = (sel == REDIR_JUMP) || (sel == REDIR_JALR) || (sel == REDIR_TRAP);

endmodule

`default_nettype wire

// File: hw/fetch_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_ctrl
    import core_pkg::*;
    import rbus_pkg::*;
(
    input  wire logic clk,
    input  wire logic rst_n_i,
    rbus_if.master    bus,
    input  wire xlen_t pc_i,
    input  wire logic redirect_i,
    input  wire logic inst_ready_i,
    input  wire logic out_valid_i,
    output logic      advance_o,
    output logic      load_o,
    output logic      clear_o,
    output rdata_t    rdata_o,
    output raddr_t    raddr_o
);

    fetch_state_e state_q;
    fetch_state_e state_d;
    raddr_t       addr_q;
    logic         stale_q;
    logic         deliver;
    logic         can_issue;

    // output register handed to the consumer this clock
    assign deliver = out_valid_i && inst_ready_i;

    // one read at a time, and only once the output slot frees up
    // a redirect this clock moves the pc, so wait one clock for it
    assign can_issue = (!out_valid_i || deliver) && !redirect_i;

    always_comb begin
        state_d = state_q;
        case (state_q)
            ST_IDLE: begin
                if (can_issue) begin
                    state_d = ST_ADDR;
                end
            end
            ST_ADDR: begin
                if (bus.ar_ready) begin
                    state_d = ST_DATA;
                end
            end
            ST_DATA: begin
                if (bus.r_valid) begin
                    state_d = ST_IDLE;
                end
            end
            default: state_d = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            state_q <= ST_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // issued address is the pc as it will be after this edge
    always_ff @(posedge clk) begin
        if ((state_q == ST_IDLE) && can_issue) begin
            addr_q <= deliver ? raddr_t'(pc_i + INST_STEP) : raddr_t'(pc_i);
        end
    end

    // read in flight across a redirect carries an old pc
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            stale_q <= 1'b0;
        end else if (state_q == ST_IDLE) begin
            stale_q <= 1'b0;
        end else if (redirect_i) begin
            stale_q <= 1'b1;
        end
    end

    // bus drive
    assign bus.ar_valid = (state_q == ST_ADDR);
    assign bus.ar_addr  = addr_q;
    assign bus.ar_size  = RSIZE_WORD;
    assign bus.r_ready  = (state_q == ST_DATA);

    // keep the data only if it is still the one we want
    assign load_o = (state_q == ST_DATA) && bus.r_valid && !stale_q
                    && (addr_q == raddr_t'(pc_i));

    assign advance_o = deliver;
    assign clear_o   = redirect_i;
    assign rdata_o   = bus.r_data;
    assign raddr_o   = addr_q;

endmodule

`default_nettype wire

// File: hw/inst_out.sv
`timescale 1ns/1ps
`default_nettype none

module inst_out
    import core_pkg::*;
    import rbus_pkg::*;
(
    input  wire logic   clk,
    input  wire logic   rst_n_i,
    input  wire logic   load_i,
    input  wire logic   clear_i,
    input  wire logic   inst_ready_i,
    input  wire rdata_t rdata_i,
    input  wire raddr_t raddr_i,
    output logic        inst_valid_o,
    output inst_t       inst_o,
    output xlen_t       pc_o
);

    inst_t sel_inst;
    logic  valid_q;
    inst_t inst_q;
    xlen_t pc_q;

    // address bit 2 picks the word within the doubleword
    assign sel_inst = raddr_i[2] ? rdata_i[63:32] : rdata_i[31:0];

    // clear beats load, a taken output empties the slot
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            valid_q <= 1'b0;
        end else if (clear_i) begin
            valid_q <= 1'b0;
        end else if (load_i) begin
            valid_q <= 1'b1;
        end else if (valid_q && inst_ready_i) begin
            valid_q <= 1'b0;
        end
    end

    // payload only moves on a load, so it holds under back-pressure
    always_ff @(posedge clk) begin
        if (load_i && !clear_i) begin
            inst_q <= sel_inst;
            pc_q   <= xlen_t'(raddr_i);
        end
    end

    assign inst_valid_o = valid_q;
    assign inst_o       = inst_q;
    assign pc_o         = pc_q;

endmodule

`default_nettype wire

// File: hw/ifetch_top.sv
`timescale 1ns/1ps
`default_nettype none

module ifetch_top
    import core_pkg::*;
    import rbus_pkg::*;
#(
    parameter xlen_t RESET_PC = 64'h0000_0000_8000_0000
) (
    input  wire logic   clk,
    input  wire logic   rst_n_i,
    // redirect sources
    input  wire logic   jal_i,
    input  wire logic   branch_i,
    input  wire logic   jalr_i,
    input  wire logic   trap_i,
    input  wire xlen_t  alu_res_i,
    input  wire xlen_t  ex_pc_i,
    input  wire xlen_t  imm_i,
    input  wire xlen_t  rs1_data_i,
    input  wire xlen_t  mtvec_i,
    // read channel
    output logic        ar_valid_o,
    input  wire logic   ar_ready_i,
    output raddr_t      ar_addr_o,
    output rsize_t      ar_size_o,
    input  wire logic   r_valid_i,
    output logic        r_ready_o,
    input  wire rdata_t r_data_i,
    // downstream
    input  wire logic   inst_ready_i,
    output logic        inst_valid_o,
    output inst_t       inst_o,
    output xlen_t       pc_o
);

    xlen_t  pc;
    logic   redirect;
    logic   advance;
    logic   load;
    logic   clear;
    rdata_t rdata;
    raddr_t raddr;

    rbus_if bus ();

    // interface onto the plain ports
    assign ar_valid_o   = bus.ar_valid;
    assign ar_addr_o    = bus.ar_addr;
    assign ar_size_o    = bus.ar_size;
    assign r_ready_o    = bus.r_ready;
    assign bus.ar_ready = ar_ready_i;
    assign bus.r_valid  = r_valid_i;
    assign bus.r_data   = r_data_i;

    pc_gen #(
        .RESET_PC(RESET_PC)
    ) pc_gen0 (
        .clk        (clk),
        .rst_n_i    (rst_n_i),
        .jal_i      (jal_i),
        .branch_i   (branch_i),
        .jalr_i     (jalr_i),
        .trap_i     (trap_i),
        .alu_res_i  (alu_res_i),
        .ex_pc_i    (ex_pc_i),
        .imm_i      (imm_i),
        .rs1_data_i (rs1_data_i),
        .mtvec_i    (mtvec_i),
        .advance_i  (advance),
        .pc_o       (pc),
        .redirect_o (redirect)
    );

    fetch_ctrl fetch_ctrl0 (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .bus          (bus.master),
        .pc_i         (pc),
        .redirect_i   (redirect),
        .inst_ready_i (inst_ready_i),
        .out_valid_i  (inst_valid_o),
        .advance_o    (advance),
        .load_o       (load),
        .clear_o      (clear),
        .rdata_o      (rdata),
        .raddr_o      (raddr)
    );

    inst_out inst_out0 (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .load_i       (load),
        .clear_i      (clear),
        .inst_ready_i (inst_ready_i),
        .rdata_i      (rdata),
        .raddr_i      (raddr),
        .inst_valid_o (inst_valid_o),
        .inst_o       (inst_o),
        .pc_o         (pc_o)
    );

endmodule

`default_nettype wire

// File: test/imem_model.sv
`timescale 1ns/1ps
`default_nettype none

// instruction memory responder for the read channel
module imem_model
    import rbus_pkg::*;
(
    input  wire logic   clk,
    input  wire logic   rst_n_i,
    input  wire logic   ar_valid_i,
    output logic        ar_ready_o,
    input  wire raddr_t ar_addr_i,
    input  wire rsize_t ar_size_i,
    output logic        r_valid_o,
    input  wire logic   r_ready_i,
    output rdata_t      r_data_o,
    output logic        size_bad_o
);

    logic [1:0] a_cnt;
    logic [1:0] d_cnt;
    logic       pending;
    raddr_t     addr_q;
    raddr_t     base;

    // word stored at byte address a
    function automatic logic [31:0] word_at(input raddr_t a);
        return a[31:0] ^ 32'hA5A5_0000;
    endfunction

    assign ar_ready_o = ar_valid_i && (a_cnt == 2'd0) && !pending;
    assign base       = {addr_q[63:3], 3'b000};

    always @(posedge clk) begin
        if (!rst_n_i) begin
            a_cnt      <= 2'($urandom % 4);
            d_cnt      <= 2'd0;
            pending    <= 1'b0;
            r_valid_o  <= 1'b0;
            r_data_o   <= '0;
            size_bad_o <= 1'b0;
        end else begin
            if (ar_valid_i && ar_ready_o) begin
                if (ar_size_i != RSIZE_WORD) begin
                    size_bad_o <= 1'b1;
                end
                addr_q  <= ar_addr_i;
                pending <= 1'b1;
                d_cnt   <= 2'($urandom % 4);
                a_cnt   <= 2'($urandom % 4);
            end else if (ar_valid_i && (a_cnt != 2'd0)) begin
                a_cnt <= a_cnt - 2'd1;
            end
            // data phase after its own delay
            if (pending && !r_valid_o) begin
                if (d_cnt == 2'd0) begin
                    r_valid_o <= 1'b1;
                    r_data_o  <= {word_at(base + 64'd4), word_at(base)};
                end else begin
                    d_cnt <= d_cnt - 2'd1;
                end
            end
            if (r_valid_o && r_ready_i) begin
                r_valid_o <= 1'b0;
                pending   <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

// File: test/ifetch_tb.sv
`timescale 1ns/1ps
`default_nettype none

module ifetch_tb
    import core_pkg::*;
    import rbus_pkg::*;
();

    localparam xlen_t START_PC = 64'h0000_0000_8000_0000;
    localparam int    TAIL     = 20;
    // event kind bits: jal, branch, jalr, trap
    localparam logic [3:0] EV_JAL  = 4'b1000;
    localparam logic [3:0] EV_BR   = 4'b0100;
    localparam logic [3:0] EV_JALR = 4'b0010;
    localparam logic [3:0] EV_TRAP = 4'b0001;

    typedef struct {
        int         n;
        logic [3:0] kind;
        xlen_t      alu;
        xlen_t      ex_pc;
        xlen_t      imm;
        xlen_t      rs1;
        xlen_t      mtvec;
        logic       redir;
        xlen_t      target;
    } event_t;

    logic   clk = 1'b0;
    logic   rst_n, jal, branch, jalr, trap, inst_ready;
    xlen_t  alu_res, ex_pc, imm, rs1_data, mtvec;
    logic   ar_valid, ar_ready, r_valid, r_ready, inst_valid, size_bad;
    raddr_t ar_addr;
    rsize_t ar_size;
    rdata_t r_data;
    inst_t  inst;
    xlen_t  pc;

    event_t events[$];
    int     dcount = 0;
    int     limit = 0;
    int     cycles = 0;
    int     errors = 0;
    logic   ev_active, ev_redir;
    xlen_t  ev_target;
    xlen_t  exp_pc = START_PC;
    logic   held_valid = 1'b0;
    inst_t  held_inst;
    xlen_t  held_pc;
    logic   addr_stale = 1'b0;

    always #2 clk = ~clk;

    ifetch_top #(.RESET_PC(START_PC)) dut0 (
        .clk(clk), .rst_n_i(rst_n),
        .jal_i(jal), .branch_i(branch), .jalr_i(jalr), .trap_i(trap),
        .alu_res_i(alu_res), .ex_pc_i(ex_pc), .imm_i(imm),
        .rs1_data_i(rs1_data), .mtvec_i(mtvec),
        .ar_valid_o(ar_valid), .ar_ready_i(ar_ready), .ar_addr_o(ar_addr),
        .ar_size_o(ar_size), .r_valid_i(r_valid), .r_ready_o(r_ready),
        .r_data_i(r_data), .inst_ready_i(inst_ready),
        .inst_valid_o(inst_valid), .inst_o(inst), .pc_o(pc)
    );

    imem_model imem0 (
        .clk(clk), .rst_n_i(rst_n), .ar_valid_i(ar_valid), .ar_ready_o(ar_ready),
        .ar_addr_i(ar_addr), .ar_size_i(ar_size), .r_valid_o(r_valid),
        .r_ready_i(r_ready), .r_data_o(r_data), .size_bad_o(size_bad)
    );

    task automatic fail_run(input string msg);
        errors++;
        $display("%s", msg);
        $display("Finished with errors");
        $fatal(1);
    endtask

    task automatic check_inst(input string name, input inst_t got, input inst_t exp);
        if (got !== exp) begin
            fail_run($sformatf("mismatch %s: got %h expected %h", name, got, exp));
        end
    endtask

    task automatic check_xlen(input string name, input xlen_t got, input xlen_t exp);
        if (got !== exp) begin
            fail_run($sformatf("mismatch %s: got %h expected %h", name, got, exp));
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            fail_run($sformatf("mismatch %s: got %h expected %h", name, got, exp));
        end
    endtask

    // expected memory word at a byte address
    function automatic inst_t expected_word(input xlen_t a);
        return a[31:0] ^ 32'hA5A5_0000;
    endfunction

    task automatic add_event(input int n, input logic [3:0] kind, input xlen_t a,
                             input xlen_t e, input xlen_t i, input xlen_t r,
                             input xlen_t m, input logic redir, input xlen_t target);
        event_t ev;
        ev = '{n, kind, a, e, i, r, m, redir, target};
        events.push_back(ev);
    endtask

    // consumer readiness, low on about 30% of clocks
    always @(posedge clk) begin
        inst_ready <= rst_n && (($urandom % 100) >= 30);
    end

    // delivery checks and hold checks
    always @(posedge clk) begin
        if (rst_n) begin
            check_bit("size_ok", !size_bad, 1'b1);
            // a read issued before a redirect carries the old pc
            if (ar_valid && ar_ready) begin
                if (!addr_stale) begin
                    check_xlen("ar_addr_o", ar_addr, exp_pc);
                end
                addr_stale = 1'b0;
            end
            if (held_valid && inst_valid) begin
                check_inst("inst_o held", inst, held_inst);
                check_xlen("pc_o held", pc, held_pc);
            end
            if (inst_valid && inst_ready) begin
                check_xlen("pc_o", pc, exp_pc);
                check_inst("inst_o", inst, expected_word(exp_pc));
                exp_pc = exp_pc + 64'd4;
                dcount <= dcount + 1;
            end
            if (ev_active && ev_redir) begin
                exp_pc = ev_target;
                if (ar_valid && !ar_ready) begin
                    addr_stale = 1'b1;
                end
            end
            held_valid = inst_valid && !inst_ready;
            held_inst  = inst;
            held_pc    = pc;
        end
    end

    // hang guard
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if ((limit > 0) && (cycles >= limit)) begin
            fail_run("hang: deliveries stopped before the end of the table");
        end
    end

    initial begin
        int target;
        int total;
        void'($urandom(32'hd6ace5c1));
        {rst_n, jal, branch, jalr, trap, inst_ready} = '0;
        {alu_res, ex_pc, imm, rs1_data, mtvec} = '0;
        {ev_active, ev_redir} = '0;
        ev_target = '0;

        add_event(3, EV_JAL, 0, 64'h8000_0100, 64'h40, 0, 0, 1'b1, 64'h8000_0140);
        add_event(2, EV_BR, 0, 64'h8000_0200, 64'h1C, 0, 0, 1'b1, 64'h8000_021C);
        // branch not taken
        add_event(2, EV_BR, 5, 64'h8000_0300, 64'h10, 0, 0, 1'b0, 0);
        add_event(3, EV_JALR, 0, 0, 64'h20, 64'h8000_0405, 0, 1'b1, 64'h8000_0424);
        // jal beats jalr
        add_event(1, EV_JAL | EV_JALR, 0, 64'h8000_0500, 64'h8, 64'h9000_0001, 0,
                  1'b1, 64'h8000_0508);
        add_event(2, EV_TRAP, 0, 0, 0, 0, 64'h8000_1000, 1'b1, 64'h8000_1000);
        add_event(0, EV_TRAP, 0, 0, 0, 0, 64'h8000_2004, 1'b1, 64'h8000_2004);
        add_event(0, EV_JALR, 0, 0, 64'h11, 64'h8000_3000, 0, 1'b1, 64'h8000_3010);
        add_event(4, EV_JAL, 0, 64'h8000_0600, 64'hFFFF_FFFF_FFFF_FF00, 0, 0,
                  1'b1, 64'h8000_0500);

        total = TAIL;
        foreach (events[k]) begin
            total += events[k].n;
        end
        limit = 40 * total;

        repeat (8) @(posedge clk);
        rst_n <= 1'b1;
        @(posedge clk);
        check_bit("ar_valid_o", ar_valid, 1'b0);
        check_bit("r_ready_o", r_ready, 1'b0);
        check_bit("inst_valid_o", inst_valid, 1'b0);

        target = 0;
        foreach (events[k]) begin
            target += events[k].n;
            while (dcount < target) @(posedge clk);
            {jal, branch, jalr, trap} <= events[k].kind;
            alu_res   <= events[k].alu;
            ex_pc     <= events[k].ex_pc;
            imm       <= events[k].imm;
            rs1_data  <= events[k].rs1;
            mtvec     <= events[k].mtvec;
            ev_active <= 1'b1;
            ev_redir  <= events[k].redir;
            ev_target <= events[k].target;
            @(posedge clk);
            {jal, branch, jalr, trap} <= 4'b0000;
            ev_active <= 1'b0;
            @(posedge clk);
        end

        while (dcount < total) @(posedge clk);
        if (errors == 0) begin
            $display("Finished with no errors");
            $finish;
        end else begin
            $display("Finished with errors");
            $fatal(1);
        end
    end

endmodule

`default_nettype wire

// File: ifetch.f
hw/core_pkg.sv
hw/rbus_pkg.sv
hw/rbus_if.sv
hw/pc_gen.sv
hw/fetch_ctrl.sv
hw/inst_out.sv
hw/ifetch_top.sv
test/imem_model.sv
test/ifetch_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the fetch testbench with Verilator.
# Exit status is nonzero when the build or the simulation fails.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing \
    --top-module ifetch_tb \
    -f ifetch.f \
    -o sim_ifetch
status=$?
if [ "$status" -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit "$status"
fi

./obj_dir/sim_ifetch
status=$?
if [ "$status" -ne 0 ]; then
    echo "simulation failed with status $status"
    exit "$status"
fi

exit 0
